// File: tb.f
src/otp_part_pkg.sv
src/otp_part_window.sv
src/otp_part_fsm.sv
src/otp_part_digest_lock.sv
src/otp_part_unbuf.sv
tests/otp_part_checker.sv
tests/tb_otp_part_unbuf.sv

// File: Bender.yml
package:
  name: otp_part_unbuf

sources:
  - files:
      - src/otp_part_pkg.sv
      - src/otp_part_window.sv
      - src/otp_part_fsm.sv
      - src/otp_part_digest_lock.sv
      - src/otp_part_unbuf.sv
  - target: test
    files:
      - tests/otp_part_checker.sv
      - tests/tb_otp_part_unbuf.sv

// File: tests/tb_otp_part_unbuf.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the OTP unbuffered partition
// Clock, reset, OTP macro model and a table of bus reads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_otp_part_unbuf;

  localparam int unsigned PartOffset  = 64;
  localparam int unsigned PartSize    = 64;
  localparam bit          ReadLockEn  = 1'b1;
  localparam bit          WriteLockEn = 1'b0;
  localparam int unsigned NumRows     = 14;
  localparam int unsigned Timeout     = 100;
  // Digest sits in the last 8 bytes, in halfwords
  localparam logic [9:0] DigestHalfAddr = 10'((PartOffset + PartSize - 8) >> 1);

  localparam otp_part_pkg::otp_err_e NoErr  = otp_part_pkg::NoError;
  localparam otp_part_pkg::otp_err_e MacErr = otp_part_pkg::MacroError;
  localparam otp_part_pkg::otp_err_e EccErr = otp_part_pkg::MacroEccCorrError;
  localparam otp_part_pkg::otp_err_e AccErr = otp_part_pkg::AccessError;
  localparam otp_part_pkg::otp_err_e FsmErr = otp_part_pkg::FsmStateError;

  // init 0 none, 1 model digest, 2 zero digest; lat 0 means with the OTP response
  typedef struct packed {
    logic [127:0]           name;
    logic [1:0]             init;
    logic [8:0]             addr;
    logic                   rlock;
    logic                   esc;
    otp_part_pkg::otp_err_e inj_err;
    logic [1:0]             rerror;
    logic [31:0]            rdata;
    otp_part_pkg::otp_err_e error;
    logic [1:0]             lat;
  } row_t;

  logic clk_i = 1'b0;
  logic rst_ni, init_req_i, init_done_o, escalate_en_i, fsm_err_o;
  logic read_lock_i, write_lock_i, read_lock_o, write_lock_o;
  logic bus_req_i, bus_gnt_o, bus_rvalid_o, otp_req_o, otp_gnt_i, otp_rvalid_i;
  logic [8:0]  bus_addr_i;
  logic [1:0]  bus_rerror_o, otp_size_o, exp_rerror, exp_lat, exp_size;
  logic [31:0] bus_rdata_o, exp_rdata;
  logic [9:0]  otp_addr_o, rd_addr;
  logic [63:0] otp_rdata_i, digest_o, exp_digest;
  logic [127:0] chk_name;
  logic [3:0]  exp_status;
  logic        status_chk, zero_digest, rd_digest;
  otp_part_pkg::otp_err_e error_o, otp_err_i, exp_error, rsp_err;
  int unsigned mismatches, responses, timeouts;
  row_t        rows [NumRows];

  always #5 clk_i = ~clk_i;

  otp_part_unbuf #(
    .PartOffset (PartOffset),
    .PartSize   (PartSize),
    .ReadLockEn (ReadLockEn),
    .WriteLockEn(WriteLockEn)
  ) i_otp_part_unbuf (
    .clk_i, .rst_ni, .init_req_i, .init_done_o, .escalate_en_i, .error_o, .fsm_err_o,
    .read_lock_i, .write_lock_i, .read_lock_o, .write_lock_o, .digest_o,
    .bus_req_i, .bus_gnt_o, .bus_addr_i, .bus_rvalid_o, .bus_rerror_o, .bus_rdata_o,
    .otp_req_o, .otp_addr_o, .otp_size_o, .otp_gnt_i, .otp_rvalid_i, .otp_rdata_i,
    .otp_err_i
  );

  otp_part_checker i_checker (
    .clk_i, .rst_ni, .name_i(chk_name), .exp_rerror_i(exp_rerror), .exp_rdata_i(exp_rdata),
    .exp_error_i(exp_error), .exp_lat_i(exp_lat), .status_chk_i(status_chk),
    .exp_status_i(exp_status), .exp_digest_i(exp_digest), .exp_size_i(exp_size),
    .bus_gnt_i(bus_gnt_o), .bus_rvalid_i(bus_rvalid_o), .bus_rerror_i(bus_rerror_o),
    .bus_rdata_i(bus_rdata_o), .error_i(error_o), .otp_req_i(otp_req_o), .otp_gnt_i,
    .otp_size_i(otp_size_o), .otp_rvalid_i, .init_done_i(init_done_o),
    .read_lock_i(read_lock_o), .write_lock_i(write_lock_o), .fsm_err_i(fsm_err_o),
    .digest_i(digest_o), .mismatch_count_o(mismatches), .rsp_count_o(responses)
  );

  // Macro content, a fixed tag over the halfword address
  function automatic logic [63:0] model_data(input logic [9:0] addr);
    return 64'hA5A5_0000_0000_0000 | 64'(addr);
  endfunction

  // Lock rule: incoming lock, uninitialized, or a set digest when enabled
  function automatic logic lock_rule(input logic lock_in, input logic init, input bit en);
    return lock_in | !init | (en & (exp_digest != '0));
  endfunction

  // OTP macro model, grant after 0 to 3 cycles and data 2 cycles later
  always begin
    @(negedge clk_i);
    if (rst_ni && otp_req_o) begin
      repeat ($urandom % 4) @(negedge clk_i);
      otp_gnt_i = 1'b1;
      rd_addr   = otp_addr_o;
      rd_digest = (otp_size_o == 2'd3);
      @(negedge clk_i);
      otp_gnt_i = 1'b0;
      @(negedge clk_i);
      otp_rvalid_i = 1'b1;
      otp_rdata_i  = (rd_digest && zero_digest) ? '0 : model_data(rd_addr);
      otp_err_i    = rsp_err;
      @(negedge clk_i);
      otp_rvalid_i = 1'b0;
      otp_rdata_i  = '0;
      otp_err_i    = NoErr;
    end
  end

  task automatic check_status(input logic [127:0] name, input logic init, input logic ferr);
    chk_name   = name;
    exp_status = {init, lock_rule(read_lock_i, init, ReadLockEn),
                  lock_rule(write_lock_i, init, WriteLockEn), ferr};
    status_chk = 1'b1;
    @(negedge clk_i);
    status_chk = 1'b0;
  endtask

  task automatic wait_init_done();
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!init_done_o && n < Timeout);
    if (!init_done_o) begin
      timeouts++;
      $display("Timeout waiting for init_done_o");
    end
  endtask

  task automatic wait_grant();
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!bus_gnt_o && n < Timeout);
    if (!bus_gnt_o) begin
      timeouts++;
      $display("Timeout waiting for the bus grant in %0s", chk_name);
    end
  endtask

  task automatic wait_response();
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!bus_rvalid_o && n < Timeout);
    if (!bus_rvalid_o) begin
      timeouts++;
      $display("Timeout waiting for the bus response in %0s", chk_name);
    end
  endtask

  task automatic reset_and_init(input logic zero);
    rst_ni       = 1'b0;
    read_lock_i  = 1'b0;
    write_lock_i = 1'b0;
    rsp_err      = NoErr;
    zero_digest  = zero;
    exp_digest   = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_status("pre_init", 1'b0, 1'b0);
    // Digest read covers four halfwords
    chk_name   = "init";
    exp_size   = 2'd3;
    init_req_i = 1'b1;
    @(negedge clk_i);
    init_req_i = 1'b0;
    wait_init_done();
    @(negedge clk_i);
    // Data reads cover two halfwords
    exp_size   = 2'd1;
    exp_digest = zero ? '0 : model_data(DigestHalfAddr);
    check_status("post_init", 1'b1, 1'b0);
    // Incoming write lock reaches the output
    write_lock_i = 1'b1;
    check_status("write_lock_in", 1'b1, 1'b0);
    write_lock_i = 1'b0;
  endtask

  task automatic apply_row(input row_t row);
    chk_name    = row.name;
    exp_rerror  = row.rerror;
    exp_rdata   = row.rdata;
    exp_error   = row.error;
    exp_lat     = row.lat;
    read_lock_i = row.rlock;
    rsp_err     = row.inj_err;
    @(negedge clk_i);
    if (row.esc) begin
      // One cycle of escalation from the idle state
      escalate_en_i = 1'b1;
      check_status(row.name, 1'b1, 1'b1);
      escalate_en_i = 1'b0;
      check_status(row.name, 1'b0, 1'b0);
    end
    bus_addr_i = row.addr;
    bus_req_i  = 1'b1;
    wait_grant();
    @(negedge clk_i);
    bus_req_i = 1'b0;
    wait_response();
    repeat (2) @(negedge clk_i);
  endtask

  initial begin
    void'($urandom(32'h14325f01));
    rst_ni        = 1'b0;
    init_req_i    = 1'b0;
    escalate_en_i = 1'b0;
    read_lock_i   = 1'b0;
    write_lock_i  = 1'b0;
    bus_req_i     = 1'b0;
    bus_addr_i    = '0;
    otp_gnt_i     = 1'b0;
    otp_rvalid_i  = 1'b0;
    otp_rdata_i   = '0;
    otp_err_i     = NoErr;
    status_chk    = 1'b0;
    zero_digest   = 1'b0;
    exp_size      = 2'd3;
    timeouts      = 0;
    // name, init, word, rlock, esc, injected, rerror, rdata, error_o, latency
    rows[0]  = '{"lock_lo", 1, 16, 0, 0, NoErr, 3, 0, AccErr, 2};
    rows[1]  = '{"lock_hi", 0, 31, 0, 0, NoErr, 3, 0, AccErr, 2};
    rows[2]  = '{"escalate", 0, 16, 0, 1, NoErr, 3, 0, FsmErr, 1};
    rows[3]  = '{"esc_after", 0, 20, 0, 0, NoErr, 3, 0, FsmErr, 1};
    rows[4]  = '{"range_below", 2, 0, 0, 0, NoErr, 3, 0, AccErr, 2};
    rows[5]  = '{"range_end", 0, 32, 0, 0, NoErr, 3, 0, AccErr, 2};
    rows[6]  = '{"data_first", 0, 16, 0, 0, NoErr, 0, 32'h20, NoErr, 0};
    rows[7]  = '{"data_last", 0, 31, 0, 0, NoErr, 0, 32'h3e, NoErr, 0};
    rows[8]  = '{"lock_in", 0, 20, 1, 0, NoErr, 3, 0, AccErr, 2};
    rows[9]  = '{"ecc_corr", 0, 17, 0, 0, EccErr, 0, 32'h22, EccErr, 0};
    rows[10] = '{"ecc_clear", 0, 18, 0, 0, NoErr, 0, 32'h24, NoErr, 0};
    rows[11] = '{"fatal", 0, 19, 0, 0, MacErr, 3, 0, MacErr, 0};
    rows[12] = '{"after_fatal", 0, 24, 0, 0, NoErr, 3, 0, MacErr, 1};
    rows[13] = '{"after_fatal2", 0, 0, 0, 0, NoErr, 3, 0, MacErr, 1};

    for (int r = 0; r < NumRows; r++) begin
      if (rows[r].init != 2'd0) begin
        reset_and_init(rows[r].init == 2'd2);
      end
      apply_row(rows[r]);
    end
    repeat (2) @(negedge clk_i);

    if (responses != NumRows) begin
      $display("mismatch response_count expected %0d actual %0d", NumRows, responses);
    end
    $display("Summary: %0d mismatches, %0d timeouts, %0d responses",
             mismatches, timeouts, responses);
    if (mismatches == 0 && timeouts == 0 && responses == NumRows) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: tests/otp_part_checker.sv
////////////////////////////////////////////////////////////////////////////
// OTP partition response checker
// Watches the bus and status ports of the partition, compares them with
// the expected values of the current table row and counts mismatches
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module otp_part_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [127:0]           name_i,
  // Expected response of the current row
  input  logic [1:0]             exp_rerror_i,
  input  logic [31:0]            exp_rdata_i,
  input  otp_part_pkg::otp_err_e exp_error_i,
  input  logic [1:0]             exp_lat_i,
  // Expected status, compared while status_chk_i is high
  input  logic                   status_chk_i,
  input  logic [3:0]             exp_status_i,
  input  logic [63:0]            exp_digest_i,
  // Expected OTP read size, compared on each OTP grant
  input  logic [1:0]             exp_size_i,
  // Watched DUT ports
  input  logic                   bus_gnt_i,
  input  logic                   bus_rvalid_i,
  input  logic [1:0]             bus_rerror_i,
  input  logic [31:0]            bus_rdata_i,
  input  otp_part_pkg::otp_err_e error_i,
  input  logic                   otp_req_i,
  input  logic                   otp_gnt_i,
  input  logic [1:0]             otp_size_i,
  input  logic                   otp_rvalid_i,
  input  logic                   init_done_i,
  input  logic                   read_lock_i,
  input  logic                   write_lock_i,
  input  logic                   fsm_err_i,
  input  logic [63:0]            digest_i,
  output int unsigned            mismatch_count_o,
  output int unsigned            rsp_count_o
);

  int unsigned cycles;
  logic        pending;
  logic        error_due;
  logic [3:0]  status;

  // Same bit order as exp_status_i
  assign status = {init_done_i, read_lock_i, write_lock_i, fsm_err_i};

  initial begin
    mismatch_count_o = 0;
    rsp_count_o      = 0;
  end

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    mismatch_count_o++;
    $display("mismatch %0s %0s expected 0x%0h actual 0x%0h", name_i, what, exp, act);
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending   <= 1'b0;
      error_due <= 1'b0;
      cycles    <= 0;
    end else begin
      error_due <= 1'b0;
      if (pending) begin
        cycles <= cycles + 1;
      end
      // Cycles are counted from the grant cycle
      if (bus_gnt_i) begin
        pending <= 1'b1;
        cycles  <= 1;
      end
      if (bus_rvalid_i) begin
        rsp_count_o++;
        pending   <= 1'b0;
        error_due <= 1'b1;
        if (!pending) begin
          mismatch_count_o++;
          $display("Response without a granted request in %0s", name_i);
        end else if (exp_lat_i == 2'd0 && !otp_rvalid_i) begin
          mismatch_count_o++;
          $display("Response in %0s is not aligned with the OTP response", name_i);
        end else if (exp_lat_i != 2'd0 && cycles != exp_lat_i) begin
          report_mismatch("latency", exp_lat_i, cycles);
        end
        if (bus_rerror_i !== exp_rerror_i) begin
          report_mismatch("rerror", exp_rerror_i, bus_rerror_i);
        end
        if (bus_rdata_i !== exp_rdata_i) begin
          report_mismatch("rdata", exp_rdata_i, bus_rdata_i);
        end
      end
      // Read size is checked when the macro accepts the request
      if (otp_req_i && otp_gnt_i && otp_size_i !== exp_size_i) begin
        report_mismatch("otp_size", exp_size_i, otp_size_i);
      end
      // error_o settles one cycle after the response
      if (error_due && error_i !== exp_error_i) begin
        report_mismatch("error_o", exp_error_i, error_i);
      end
      if (status_chk_i) begin
        if (status !== exp_status_i) begin
          report_mismatch("status", exp_status_i, status);
        end
        if (digest_i !== exp_digest_i) begin
          report_mismatch("digest", exp_digest_i, digest_i);
        end
      end
    end
  end

endmodule

// File: src/otp_part_unbuf.sv
////////////////////////////////////////////////////////////////////////////
// OTP unbuffered partition
// Digest readout on init, software reads through a word window, error
// reporting and lock outputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module otp_part_unbuf #(
  parameter int unsigned PartOffset  = 64,
  parameter int unsigned PartSize    = 64,
  parameter bit          ReadLockEn  = 1'b0,
  parameter bit          WriteLockEn = 1'b0
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Init and status
  input  logic                                       init_req_i,
  output logic                                       init_done_o,
  input  logic                                       escalate_en_i,
  output otp_part_pkg::otp_err_e                     error_o,
  output logic                                       fsm_err_o,
  // Locks and digest
  input  logic                                       read_lock_i,
  input  logic                                       write_lock_i,
  output logic                                       read_lock_o,
  output logic                                       write_lock_o,
  output logic [otp_part_pkg::DigestWidth-1:0]       digest_o,
  // Bus window
  input  logic                                       bus_req_i,
  output logic                                       bus_gnt_o,
  input  logic [otp_part_pkg::SwWindowAddrWidth-1:0] bus_addr_i,
  output logic                                       bus_rvalid_o,
  output logic [1:0]                                 bus_rerror_o,
  output logic [otp_part_pkg::BusDataWidth-1:0]      bus_rdata_o,
  // OTP macro
  output logic                                       otp_req_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0]      otp_addr_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0]      otp_size_o,
  input  logic                                       otp_gnt_i,
  input  logic                                       otp_rvalid_i,
  input  logic [otp_part_pkg::DigestWidth-1:0]       otp_rdata_i,
  input  otp_part_pkg::otp_err_e                     otp_err_i
);

  logic addr_in_range;
  logic addr_sel_digest;
  logic rsp_ok;
  logic digest_wr_en;
  logic check_err;

  otp_part_window #(
    .PartOffset (PartOffset),
    .PartSize   (PartSize)
  ) i_window (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bus_addr_i        (bus_addr_i),
    .grant_i           (bus_gnt_o),
    .addr_sel_digest_i (addr_sel_digest),
    .rsp_ok_i          (rsp_ok),
    .otp_rdata_i       (otp_rdata_i),
    .addr_in_range_o   (addr_in_range),
    .otp_addr_o        (otp_addr_o),
    .otp_size_o        (otp_size_o),
    .bus_rdata_o       (bus_rdata_o)
  );

  // FSM checks reads against the aggregated read lock
  otp_part_fsm i_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .init_req_i        (init_req_i),
    .escalate_en_i     (escalate_en_i),
    .bus_req_i         (bus_req_i),
    .addr_in_range_i   (addr_in_range),
    .read_lock_i       (read_lock_o),
    .check_err_i       (check_err),
    .otp_gnt_i         (otp_gnt_i),
    .otp_rvalid_i      (otp_rvalid_i),
    .otp_err_i         (otp_err_i),
    .init_done_o       (init_done_o),
    .bus_gnt_o         (bus_gnt_o),
    .bus_rvalid_o      (bus_rvalid_o),
    .bus_rerror_o      (bus_rerror_o),
    .rsp_ok_o          (rsp_ok),
    .otp_req_o         (otp_req_o),
    .addr_sel_digest_o (addr_sel_digest),
    .digest_wr_en_o    (digest_wr_en),
    .error_o           (error_o),
    .fsm_err_o         (fsm_err_o)
  );

  otp_part_digest_lock #(
    .ReadLockEn  (ReadLockEn),
    .WriteLockEn (WriteLockEn)
  ) i_digest_lock (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wr_en_i      (digest_wr_en),
    .wdata_i      (otp_rdata_i),
    .init_done_i  (init_done_o),
    .read_lock_i  (read_lock_i),
    .write_lock_i (write_lock_i),
    .digest_o     (digest_o),
    .check_err_o  (check_err),
    .read_lock_o  (read_lock_o),
    .write_lock_o (write_lock_o)
  );

endmodule

// File: src/otp_part_digest_lock.sv
////////////////////////////////////////////////////////////////////////////
// OTP partition digest register and lock aggregation
// Holds the digest with per-byte parity and merges the incoming locks
// with the init state and the digest-based locks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module otp_part_digest_lock #(
  parameter bit ReadLockEn  = 1'b0,
  parameter bit WriteLockEn = 1'b0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 wr_en_i,
  input  logic [otp_part_pkg::DigestWidth-1:0] wdata_i,
  input  logic                                 init_done_i,
  input  logic                                 read_lock_i,
  input  logic                                 write_lock_i,
  output logic [otp_part_pkg::DigestWidth-1:0] digest_o,
  output logic                                 check_err_o,
  output logic                                 read_lock_o,
  output logic                                 write_lock_o
);

  localparam int unsigned NumBytes = otp_part_pkg::DigestWidth / 8;

  logic [otp_part_pkg::DigestWidth-1:0] digest_q;
  logic [NumBytes-1:0]                  par_d, par_q, par_err;
  logic                                 digest_set;

  // Even parity per byte, both for the write and for the stored value
  always_comb begin
    for (int i = 0; i < NumBytes; i++) begin
      par_d[i]   = ^wdata_i[8*i +: 8];
      par_err[i] = ^{digest_q[8*i +: 8], par_q[i]};
    end
  end

  // All zero is a consistent parity pair out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
      par_q    <= '0;
    end else if (wr_en_i) begin
      digest_q <= wdata_i;
      par_q    <= par_d;
    end
  end

  assign digest_o    = digest_q;
  assign check_err_o = |par_err;

  ////////////////////////////////////////////////////////////////////////////
  // Lock aggregation
  ////////////////////////////////////////////////////////////////////////////

  // A programmed digest locks when the partition is configured for it
  assign digest_set   = |digest_q;
  assign read_lock_o  = read_lock_i  | ~init_done_i | (ReadLockEn  & digest_set);
  assign write_lock_o = write_lock_i | ~init_done_i | (WriteLockEn & digest_set);

  // Incoming locks always reach the outputs
  lock_propagates_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (read_lock_i |-> read_lock_o) and (write_lock_i |-> write_lock_o)
  );

  // Uninitialized partition stays locked
  uninit_locked_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !init_done_i |-> read_lock_o && write_lock_o
  );

endmodule

// File: src/otp_part_fsm.sv
////////////////////////////////////////////////////////////////////////////
// OTP partition control FSM
// Reads the digest on init, serves bus reads with range and lock checks,
// latches error codes and locks down on fatal errors and escalation
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module otp_part_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   init_req_i,
  input  logic                   escalate_en_i,
  input  logic                   bus_req_i,
  input  logic                   addr_in_range_i,
  input  logic                   read_lock_i,
  input  logic                   check_err_i,
  input  logic                   otp_gnt_i,
  input  logic                   otp_rvalid_i,
  input  otp_part_pkg::otp_err_e otp_err_i,
  output logic                   init_done_o,
  output logic                   bus_gnt_o,
  output logic                   bus_rvalid_o,
  output logic [1:0]             bus_rerror_o,
  output logic                   rsp_ok_o,
  output logic                   otp_req_o,
  output logic                   addr_sel_digest_o,
  output logic                   digest_wr_en_o,
  output otp_part_pkg::otp_err_e error_o,
  output logic                   fsm_err_o
);

  otp_part_pkg::part_state_e state_d, state_q;
  otp_part_pkg::otp_err_e    error_d, error_q;

  // A granted request still owes an error response
  logic pend_d, pend_q;

  // OTP response that does not end in the error state
  logic otp_ok;

  assign otp_ok = (otp_err_i == otp_part_pkg::NoError) ||
                  (otp_err_i == otp_part_pkg::MacroEccCorrError);

  always_comb begin
    state_d           = state_q;
    error_d           = error_q;
    pend_d            = 1'b0;
    init_done_o       = 1'b0;
    bus_gnt_o         = 1'b0;
    bus_rvalid_o      = 1'b0;
    bus_rerror_o      = 2'b00;
    otp_req_o         = 1'b0;
    addr_sel_digest_o = 1'b1;
    digest_wr_en_o    = 1'b0;
    fsm_err_o         = 1'b0;

    case (state_q)
      // Wait for the one init request
      otp_part_pkg::ResetSt: begin
        if (init_req_i) begin
          state_d = otp_part_pkg::InitSt;
        end
      end
      // Digest read, held until granted
      otp_part_pkg::InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = otp_part_pkg::InitWaitSt;
        end
      end
      // Store the digest, keep a correctable ECC code as a warning
      otp_part_pkg::InitWaitSt: begin
        if (otp_rvalid_i) begin
          digest_wr_en_o = 1'b1;
          error_d        = otp_err_i;
          state_d        = otp_ok ? otp_part_pkg::IdleSt : otp_part_pkg::ErrorSt;
        end
      end
      // Grant a request, which clears recoverable codes
      otp_part_pkg::IdleSt: begin
        init_done_o = 1'b1;
        if (bus_req_i) begin
          bus_gnt_o = 1'b1;
          error_d   = otp_part_pkg::NoError;
          state_d   = otp_part_pkg::ReadSt;
        end
      end
      // Range and lock check on the latched address
      otp_part_pkg::ReadSt: begin
        init_done_o = 1'b1;
        if (addr_in_range_i && !read_lock_i) begin
          otp_req_o         = 1'b1;
          addr_sel_digest_o = 1'b0;
          if (otp_gnt_i) begin
            state_d = otp_part_pkg::ReadWaitSt;
          end
        end else begin
          // Rejected, answered one cycle later from ReadWaitSt
          error_d = otp_part_pkg::AccessError;
          pend_d  = 1'b1;
          state_d = otp_part_pkg::ReadWaitSt;
        end
      end
      // Forward the OTP response, or the pending reject
      otp_part_pkg::ReadWaitSt: begin
        init_done_o       = 1'b1;
        addr_sel_digest_o = 1'b0;
        if (pend_q) begin
          bus_rvalid_o = 1'b1;
          bus_rerror_o = 2'b11;
          state_d      = otp_part_pkg::IdleSt;
        end else if (otp_rvalid_i) begin
          bus_rvalid_o = 1'b1;
          error_d      = otp_err_i;
          if (otp_ok) begin
            state_d = otp_part_pkg::IdleSt;
          end else begin
            bus_rerror_o = 2'b11;
            state_d      = otp_part_pkg::ErrorSt;
          end
        end
      end
      // Terminal state, every request gets a bus error
      otp_part_pkg::ErrorSt: begin
        if (error_q == otp_part_pkg::NoError) begin
          error_d = otp_part_pkg::FsmStateError;
        end
        if (pend_q) begin
          bus_rvalid_o = 1'b1;
          bus_rerror_o = 2'b11;
        end else if (bus_req_i) begin
          bus_gnt_o = 1'b1;
          pend_d    = 1'b1;
        end
      end
      // Unused encoding, treat as a glitch
      default: begin
        state_d   = otp_part_pkg::ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    ////////////////////////////////////////////////////////////////////////////
    // Lockdown, overrides the state logic above
    ////////////////////////////////////////////////////////////////////////////

    // Digest register integrity failure
    if (check_err_i) begin
      state_d = otp_part_pkg::ErrorSt;
      if (state_q != otp_part_pkg::ErrorSt) begin
        error_d = otp_part_pkg::CheckFailError;
      end
    end
    // Escalation wins over the check failure code
    if (escalate_en_i) begin
      state_d   = otp_part_pkg::ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != otp_part_pkg::ErrorSt) begin
        error_d = otp_part_pkg::FsmStateError;
      end
    end
    // An outstanding request is answered from ErrorSt
    if ((check_err_i || escalate_en_i) && !bus_rvalid_o &&
        (bus_gnt_o || state_q inside {otp_part_pkg::ReadSt, otp_part_pkg::ReadWaitSt})) begin
      pend_d = 1'b1;
    end
  end

  assign rsp_ok_o = bus_rvalid_o && (bus_rerror_o == 2'b00);
  assign error_o  = error_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= otp_part_pkg::ResetSt;
      error_q <= otp_part_pkg::NoError;
      pend_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      error_q <= error_d;
      pend_q  <= pend_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // A read granted while locked ends in a bus error two cycles on
  read_on_lock_errors_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (bus_gnt_o && state_q == otp_part_pkg::IdleSt && !escalate_en_i && !check_err_i)
    ##1 read_lock_i |=> bus_rvalid_o && bus_rerror_o == 2'b11
  );

  // Digest integrity failure locks the partition down
  check_err_to_error_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    check_err_i |=> state_q == otp_part_pkg::ErrorSt
  );

endmodule

// File: src/otp_part_window.sv
////////////////////////////////////////////////////////////////////////////
// OTP partition bus window
// Latches the bus word address, checks it against the partition range,
// builds the OTP halfword address and size, and gates the read data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module otp_part_window #(
  parameter int unsigned PartOffset = 0,
  parameter int unsigned PartSize   = 64
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic [otp_part_pkg::SwWindowAddrWidth-1:0] bus_addr_i,
  input  logic                                       grant_i,
  input  logic                                       addr_sel_digest_i,
  input  logic                                       rsp_ok_i,
  input  logic [otp_part_pkg::DigestWidth-1:0]       otp_rdata_i,
  output logic                                       addr_in_range_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0]      otp_addr_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0]      otp_size_o,
  output logic [otp_part_pkg::BusDataWidth-1:0]      bus_rdata_o
);

  localparam int unsigned BaW = otp_part_pkg::OtpByteAddrWidth;
  localparam int unsigned Sh  = otp_part_pkg::OtpAddrShift;

  // Bounds carry one extra bit so the end of a top partition still fits
  localparam logic [BaW:0] PartStart = (BaW+1)'(PartOffset);
  localparam logic [BaW:0] PartEnd   = PartStart + (BaW+1)'(PartSize);

  // Digest sits in the last block of the partition
  localparam logic [BaW:0] DigestByteAddr =
      PartEnd - (BaW+1)'(otp_part_pkg::DigestWidth / 8);
  localparam logic [otp_part_pkg::OtpAddrWidth-1:0] DigestHalfAddr =
      DigestByteAddr[BaW-1:Sh];

  // Halfwords minus one per access
  localparam logic [otp_part_pkg::OtpSizeWidth-1:0] DigestSize =
      otp_part_pkg::OtpSizeWidth'(otp_part_pkg::DigestWidth / otp_part_pkg::OtpWidth - 1);
  localparam logic [otp_part_pkg::OtpSizeWidth-1:0] WordSize =
      otp_part_pkg::OtpSizeWidth'(otp_part_pkg::BusDataWidth / otp_part_pkg::OtpWidth - 1);

  logic [otp_part_pkg::SwWindowAddrWidth-1:0] addr_q;
  logic [BaW-1:0]                             byte_addr;

  // Address latch, loaded on the bus grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (grant_i) begin
      addr_q <= bus_addr_i;
    end
  end

  // Word address to byte address
  assign byte_addr = {addr_q, 2'b00};

  // Range check against [PartStart, PartEnd)
  assign addr_in_range_o = ({1'b0, byte_addr} >= PartStart) &&
                           ({1'b0, byte_addr} <  PartEnd);

  // OTP works on halfwords
  assign otp_addr_o = addr_sel_digest_i ? DigestHalfAddr : byte_addr[BaW-1:Sh];
  assign otp_size_o = addr_sel_digest_i ? DigestSize : WordSize;

  // Lower word only, and zero on any error response
  assign bus_rdata_o = rsp_ok_i ? otp_rdata_i[otp_part_pkg::BusDataWidth-1:0] : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Range check and OTP address must never see an unknown address
  addr_known_after_grant_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    grant_i |=> !$isunknown(addr_q)
  );

endmodule

// File: src/otp_part_pkg.sv
////////////////////////////////////////////////////////////////////////////
// OTP unbuffered partition package
// Shared widths of the bus window and the OTP macro interface, the
// partition error codes and the control FSM states
////////////////////////////////////////////////////////////////////////////

package otp_part_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Digest width, also the width of one OTP read beat
  parameter int unsigned DigestWidth = 64;

  // Software read data
  parameter int unsigned BusDataWidth = 32;

  // OTP macro addressing, in bytes and in halfwords
  parameter int unsigned OtpByteAddrWidth = 11;
  parameter int unsigned OtpAddrShift     = 1;
  parameter int unsigned OtpAddrWidth     = OtpByteAddrWidth - OtpAddrShift;

  // Word address of the software window
  parameter int unsigned SwWindowAddrWidth = OtpByteAddrWidth - 2;

  // Read size field counts halfwords minus one
  parameter int unsigned OtpSizeWidth = 2;
  parameter int unsigned OtpWidth     = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Error codes
  ////////////////////////////////////////////////////////////////////////////

  // Recoverable: NoError, MacroEccCorrError, AccessError
  // Everything else ends in the terminal error state
  typedef enum logic [2:0] {
    NoError             = 3'h0,
    MacroError          = 3'h1,
    MacroEccCorrError   = 3'h2,
    MacroEccUncorrError = 3'h3,
    AccessError         = 3'h4,
    CheckFailError      = 3'h5,
    FsmStateError       = 3'h6
  } otp_err_e;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM states
  ////////////////////////////////////////////////////////////////////////////

  // Code 3'h7 is unused and trapped by the FSM default branch
  typedef enum logic [2:0] {
    ResetSt    = 3'h0,
    InitSt     = 3'h1,
    InitWaitSt = 3'h2,
    IdleSt     = 3'h3,
    ReadSt     = 3'h4,
    ReadWaitSt = 3'h5,
    ErrorSt    = 3'h6
  } part_state_e;

endpackage
